// File: standby_defines.svh
// Bus codes, queue word widths and synchronizer depth for the standby target
`ifndef STANDBY_DEFINES_SVH
`define STANDBY_DEFINES_SVH

// Flops on each of SCL and SDA before decode
`define STBY_SYNC_STAGES 2

// I3C broadcast address
`define STBY_BCAST_ADDR 7'h7E

// Broadcast RSTACT command code
`define STBY_CCC_RSTACT 8'h2A

// Queue word widths
`define STBY_RX_DATA_W 8
`define STBY_DESC_W 32

`endif

// File: standby_pkg.sv
// Bus event, received byte, first-byte views and RX descriptor types
`include "standby_defines.svh"

package standby_pkg;

  // One-cycle condition pulses plus the synchronized data level
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_event_t;

  typedef struct packed {
    logic [`STBY_RX_DATA_W-1:0] data;
    logic                       valid;
    logic                       is_first;
  } rx_byte_t;

  // Header byte after START or repeated START
  typedef struct packed {
    logic [6:0] addr;
    logic       rnw;
  } addr_byte_t;

  // Command byte after a broadcast write
  typedef struct packed {
    logic       direct;
    logic [6:0] code;
  } ccc_byte_t;

  typedef union packed {
    addr_byte_t as_addr;
    ccc_byte_t  as_ccc;
  } first_byte_u;

  typedef struct packed {
    logic [`STBY_DESC_W-27:0] reserved;
    logic                     ccc;
    logic                     overflow;
    logic                     rnw;
    logic [6:0]               addr;
    logic [15:0]              byte_count;
  } rx_desc_t;

endpackage

// File: bus_cond_detect.sv
// SCL/SDA synchronizer with START, repeated START, STOP and SCL edge decode
`timescale 1ns/1ps
`include "standby_defines.svh"

module bus_cond_detect (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    scl_i,
  input  logic                    sda_i,
  output standby_pkg::bus_event_t bus_event_o
);

  logic [`STBY_SYNC_STAGES-1:0] scl_sync;
  logic [`STBY_SYNC_STAGES-1:0] sda_sync;
  logic                         scl_s;
  logic                         sda_s;
  logic                         scl_q;
  logic                         sda_q;
  logic                         busy_q;
  logic                         sda_fall_hi;
  logic                         sda_rise_hi;

  // Idle bus reads high on both lines
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scl_sync <= '1;
      sda_sync <= '1;
    end else begin
      scl_sync <= {scl_sync[`STBY_SYNC_STAGES-2:0], scl_i};
      sda_sync <= {sda_sync[`STBY_SYNC_STAGES-2:0], sda_i};
    end
  end

  assign scl_s = scl_sync[`STBY_SYNC_STAGES-1];
  assign sda_s = sda_sync[`STBY_SYNC_STAGES-1];

  // Data line moving while clock stays high
  assign sda_fall_hi = scl_s & scl_q & sda_q & ~sda_s;
  assign sda_rise_hi = scl_s & scl_q & ~sda_q & sda_s;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      busy_q      <= 1'b0;
      bus_event_o <= '{sda: 1'b1, default: 1'b0};
    end else begin
      scl_q                <= scl_s;
      sda_q                <= sda_s;
      bus_event_o.start    <= sda_fall_hi & ~busy_q;
      bus_event_o.rstart   <= sda_fall_hi & busy_q;
      bus_event_o.stop     <= sda_rise_hi;
      bus_event_o.scl_rise <= scl_s & ~scl_q;
      bus_event_o.scl_fall <= ~scl_s & scl_q;
      bus_event_o.sda      <= sda_s;
      if (sda_fall_hi) begin
        busy_q <= 1'b1;
      end else if (sda_rise_hi) begin
        busy_q <= 1'b0;
      end
    end
  end

  // At most one bus condition per cycle
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({bus_event_o.start, bus_event_o.rstart, bus_event_o.stop}));

endmodule

// File: bus_byte_shifter.sv
// Bit to byte shifter with ninth-clock ACK drive on open-drain SDA
`timescale 1ns/1ps
`include "standby_defines.svh"

module bus_byte_shifter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  standby_pkg::bus_event_t bus_event_i,
  input  logic                    ack_en_i,
  output standby_pkg::rx_byte_t   rx_byte_o,
  output logic                    sda_o
);

  logic [3:0]                 bit_cnt_q;
  logic                       active_q;
  logic                       first_q;
  logic [6:0]                 shift_q;
  logic                       ack_drive_q;
  logic                       byte_valid_q;
  logic                       byte_first_q;
  logic [`STBY_RX_DATA_W-1:0] byte_data_q;
  logic                       bit_rise;
  logic                       last_bit;
  logic                       any_start;

  assign any_start = bus_event_i.start | bus_event_i.rstart;
  assign bit_rise  = active_q & bus_event_i.scl_rise;
  assign last_bit  = (bit_cnt_q == 4'd7);

  // Framing: counts 0..7 for data bits, 8 for the ACK clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q <= '0;
      active_q  <= 1'b0;
      first_q   <= 1'b0;
    end else if (any_start) begin
      bit_cnt_q <= '0;
      active_q  <= 1'b1;
      first_q   <= 1'b1;
    end else if (bus_event_i.stop) begin
      bit_cnt_q <= '0;
      active_q  <= 1'b0;
      first_q   <= 1'b0;
    end else if (bit_rise) begin
      if (bit_cnt_q == 4'd8) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
      if (last_bit) begin
        first_q <= 1'b0;
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (bit_rise && bit_cnt_q < 4'd7) begin
      shift_q <= {shift_q[5:0], bus_event_i.sda};
    end
    if (bit_rise && last_bit) begin
      byte_data_q  <= {shift_q, bus_event_i.sda};
      byte_first_q <= first_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      byte_valid_q <= 1'b0;
    end else begin
      byte_valid_q <= bit_rise & last_bit & ~any_start & ~bus_event_i.stop;
    end
  end

  always_comb begin
    rx_byte_o.data     = byte_data_q;
    rx_byte_o.valid    = byte_valid_q;
    rx_byte_o.is_first = byte_first_q;
  end

  // Hold SDA low from the fall after bit 8 to the fall after the ninth clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_drive_q <= 1'b0;
    end else if (any_start || bus_event_i.stop) begin
      ack_drive_q <= 1'b0;
    end else if (bus_event_i.scl_fall) begin
      ack_drive_q <= active_q && (bit_cnt_q == 4'd8) && ack_en_i;
    end
  end

  assign sda_o = ~ack_drive_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i) bit_cnt_q <= 4'd8);

endmodule

// File: target_responder.sv
// Address match, RSTACT CCC, RX data and descriptor writes and ACK decision
`timescale 1ns/1ps
`include "standby_defines.svh"

module target_responder (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  standby_pkg::bus_event_t    bus_event_i,
  input  standby_pkg::rx_byte_t      rx_byte_i,
  input  logic                       i3c_mode_i,
  input  logic [6:0]                 target_sta_addr_i,
  input  logic [6:0]                 target_dyn_addr_i,
  input  logic                       target_dyn_addr_valid_i,
  output logic                       ack_en_o,
  output logic                       rx_queue_wvalid_o,
  input  logic                       rx_queue_wready_i,
  output logic [`STBY_RX_DATA_W-1:0] rx_queue_wdata_o,
  output logic                       rx_desc_queue_wvalid_o,
  input  logic                       rx_desc_queue_wready_i,
  output standby_pkg::rx_desc_t      rx_desc_queue_wdata_o,
  output logic [7:0]                 bus_addr_o,
  output logic                       bus_addr_valid_o,
  output logic [7:0]                 rst_action_o
);

  localparam logic [2:0] StIdle    = 3'd0;
  localparam logic [2:0] StData    = 3'd1;
  localparam logic [2:0] StCcc     = 3'd2;
  localparam logic [2:0] StDefByte = 3'd3;
  localparam logic [2:0] StCccIgn  = 3'd4;
  localparam logic [2:0] StNack    = 3'd5;

  localparam logic [7:0] RstactCode = `STBY_CCC_RSTACT;

  standby_pkg::first_byte_u   first_byte;
  logic [2:0]                 state_q;
  logic                       uni_match;
  logic                       bcast_match;
  logic                       matched;
  logic                       is_rstact;
  logic                       data_pend_q;
  logic                       desc_pend_q;
  logic [`STBY_RX_DATA_W-1:0] data_q;
  logic [15:0]                byte_count_q;
  logic                       overflow_q;
  logic                       ccc_q;
  logic [6:0]                 desc_addr_q;

  assign first_byte = rx_byte_i.data;

  // I2C uses the static address, I3C the dynamic one plus broadcast
  assign uni_match = i3c_mode_i ?
                     (target_dyn_addr_valid_i &&
                      first_byte.as_addr.addr == target_dyn_addr_i) :
                     (first_byte.as_addr.addr == target_sta_addr_i);
  assign bcast_match = i3c_mode_i && (first_byte.as_addr.addr == `STBY_BCAST_ADDR);

  assign is_rstact = (first_byte.as_ccc.direct == RstactCode[7]) &&
                     (first_byte.as_ccc.code == RstactCode[6:0]);

  assign matched = (state_q == StData) || (state_q == StCcc) ||
                   (state_q == StDefByte) || (state_q == StCccIgn);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q          <= StIdle;
      ack_en_o         <= 1'b0;
      data_pend_q      <= 1'b0;
      desc_pend_q      <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      byte_count_q     <= '0;
      overflow_q       <= 1'b0;
      ccc_q            <= 1'b0;
      rst_action_o     <= '0;
    end else begin
      data_pend_q      <= 1'b0;
      desc_pend_q      <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      // Write cycle decides both the queue push and the ACK
      if (data_pend_q) begin
        ack_en_o <= rx_queue_wready_i;
        if (rx_queue_wready_i) begin
          byte_count_q <= byte_count_q + 16'd1;
        end else begin
          overflow_q <= 1'b1;
        end
      end
      if (bus_event_i.stop || bus_event_i.rstart) begin
        desc_pend_q <= matched;
        state_q     <= StIdle;
      end else if (rx_byte_i.valid && rx_byte_i.is_first) begin
        bus_addr_valid_o <= 1'b1;
        byte_count_q     <= '0;
        overflow_q       <= 1'b0;
        ccc_q            <= 1'b0;
        if (!first_byte.as_addr.rnw && uni_match) begin
          state_q  <= StData;
          ack_en_o <= 1'b1;
        end else if (!first_byte.as_addr.rnw && bcast_match) begin
          state_q  <= StCcc;
          ack_en_o <= 1'b1;
        end else begin
          state_q  <= StNack;
          ack_en_o <= 1'b0;
        end
      end else if (rx_byte_i.valid) begin
        case (state_q)
          StData: data_pend_q <= 1'b1;
          StCcc: begin
            ack_en_o <= 1'b1;
            if (is_rstact) begin
              ccc_q   <= 1'b1;
              state_q <= StDefByte;
            end else begin
              state_q <= StCccIgn;
            end
          end
          StDefByte: begin
            rst_action_o <= rx_byte_i.data;
            ack_en_o     <= 1'b1;
            state_q      <= StCccIgn;
          end
          StCccIgn: ack_en_o <= 1'b1;
          default:  ack_en_o <= 1'b0;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_byte_i.valid) begin
      data_q <= rx_byte_i.data;
      if (rx_byte_i.is_first) begin
        bus_addr_o  <= rx_byte_i.data;
        desc_addr_q <= first_byte.as_addr.addr;
      end
    end
  end

  assign rx_queue_wvalid_o      = data_pend_q & rx_queue_wready_i;
  assign rx_queue_wdata_o       = data_q;
  assign rx_desc_queue_wvalid_o = desc_pend_q & rx_desc_queue_wready_i;

  // Only write transfers reach a descriptor
  always_comb begin
    rx_desc_queue_wdata_o            = '0;
    rx_desc_queue_wdata_o.byte_count = byte_count_q;
    rx_desc_queue_wdata_o.addr       = desc_addr_q;
    rx_desc_queue_wdata_o.rnw        = 1'b0;
    rx_desc_queue_wdata_o.overflow   = overflow_q;
    rx_desc_queue_wdata_o.ccc        = ccc_q;
  end

  // A data push follows a byte strobe of a matched write, with room in the queue
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rx_queue_wvalid_o |-> rx_queue_wready_i && $past(rx_byte_i.valid) &&
                          state_q == StData);

endmodule

// File: controller_standby.sv
// Standby target top joining condition decode, byte shifter and responder
`timescale 1ns/1ps
`include "standby_defines.svh"

module controller_standby (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output logic                       sda_o,
  output logic                       rx_queue_wvalid_o,
  input  logic                       rx_queue_wready_i,
  output logic [`STBY_RX_DATA_W-1:0] rx_queue_wdata_o,
  output logic                       rx_desc_queue_wvalid_o,
  input  logic                       rx_desc_queue_wready_i,
  output standby_pkg::rx_desc_t      rx_desc_queue_wdata_o,
  output logic                       bus_start_o,
  output logic                       bus_rstart_o,
  output logic                       bus_stop_o,
  output logic [7:0]                 bus_addr_o,
  output logic                       bus_addr_valid_o,
  input  logic                       i3c_mode_i,
  input  logic [6:0]                 target_sta_addr_i,
  input  logic [6:0]                 target_dyn_addr_i,
  input  logic                       target_dyn_addr_valid_i,
  output logic [7:0]                 rst_action_o
);

  standby_pkg::bus_event_t bus_event;
  standby_pkg::rx_byte_t   rx_byte;
  logic                    ack_en;

  assign bus_start_o  = bus_event.start;
  assign bus_rstart_o = bus_event.rstart;
  assign bus_stop_o   = bus_event.stop;

  bus_cond_detect u_bus_cond_detect (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .bus_event_o (bus_event)
  );

  bus_byte_shifter u_bus_byte_shifter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .bus_event_i (bus_event),
    .ack_en_i    (ack_en),
    .rx_byte_o   (rx_byte),
    .sda_o       (sda_o)
  );

  target_responder u_target_responder (
    .clk_i                   (clk_i),
    .arst_n_i                (arst_n_i),
    .bus_event_i             (bus_event),
    .rx_byte_i               (rx_byte),
    .i3c_mode_i              (i3c_mode_i),
    .target_sta_addr_i       (target_sta_addr_i),
    .target_dyn_addr_i       (target_dyn_addr_i),
    .target_dyn_addr_valid_i (target_dyn_addr_valid_i),
    .ack_en_o                (ack_en),
    .rx_queue_wvalid_o       (rx_queue_wvalid_o),
    .rx_queue_wready_i       (rx_queue_wready_i),
    .rx_queue_wdata_o        (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o  (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wready_i  (rx_desc_queue_wready_i),
    .rx_desc_queue_wdata_o   (rx_desc_queue_wdata_o),
    .bus_addr_o              (bus_addr_o),
    .bus_addr_valid_o        (bus_addr_valid_o),
    .rst_action_o            (rst_action_o)
  );

endmodule

// File: tb_controller_standby.sv
// Testbench with bus master tasks, queue model, stimulus table, checks and watchdog
`timescale 1ns/1ps
`include "standby_defines.svh"

module tb_controller_standby;

  localparam int         N_ROWS       = 10;
  localparam int         ENTRY_CYCLES = 800;
  localparam logic [6:0] STA_ADDR     = 7'h2C;
  localparam logic [6:0] DYN_ADDR     = 7'h35;

  // Columns: i3c, dyn_valid, addr_byte, nbytes, rstact, end_rstart, wready mask, ack mask
  typedef struct packed {
    logic       i3c;
    logic       dyn_valid;
    logic [7:0] addr_byte;
    logic [2:0] nbytes;
    logic       rstact;
    logic       end_rstart;
    logic [3:0] wready_mask;
    logic [4:0] ack_mask;
  } test_row_t;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       scl_drv;
  logic                       sda_drv;
  wire                        sda_bus;
  logic                       sda_o;
  logic                       rx_queue_wvalid_o;
  logic                       rx_queue_wready_i;
  logic [`STBY_RX_DATA_W-1:0] rx_queue_wdata_o;
  logic                       rx_desc_queue_wvalid_o;
  logic                       rx_desc_queue_wready_i;
  standby_pkg::rx_desc_t      rx_desc_queue_wdata_o;
  logic                       bus_start_o;
  logic                       bus_rstart_o;
  logic                       bus_stop_o;
  logic [7:0]                 bus_addr_o;
  logic                       bus_addr_valid_o;
  logic                       i3c_mode_i;
  logic [6:0]                 target_sta_addr_i;
  logic [6:0]                 target_dyn_addr_i;
  logic                       target_dyn_addr_valid_i;
  logic [7:0]                 rst_action_o;

  test_row_t   rows [N_ROWS];
  string       names [N_ROWS];
  logic [7:0]  data_seen [$];
  logic [31:0] desc_seen [$];
  logic [7:0]  addr_seen [$];
  int          start_cnt = 0;
  int          rstart_cnt = 0;
  int          stop_cnt = 0;
  integer      seed;
  logic        in_rstart;
  logic [7:0]  exp_rst_action;

  // Open-drain SDA shared by master and target
  assign sda_bus = sda_drv & sda_o;

  controller_standby UUT (
    .clk_i                   (clk_i),
    .arst_n_i                (arst_n_i),
    .scl_i                   (scl_drv),
    .sda_i                   (sda_bus),
    .sda_o                   (sda_o),
    .rx_queue_wvalid_o       (rx_queue_wvalid_o),
    .rx_queue_wready_i       (rx_queue_wready_i),
    .rx_queue_wdata_o        (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o  (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wready_i  (rx_desc_queue_wready_i),
    .rx_desc_queue_wdata_o   (rx_desc_queue_wdata_o),
    .bus_start_o             (bus_start_o),
    .bus_rstart_o            (bus_rstart_o),
    .bus_stop_o              (bus_stop_o),
    .bus_addr_o              (bus_addr_o),
    .bus_addr_valid_o        (bus_addr_valid_o),
    .i3c_mode_i              (i3c_mode_i),
    .target_sta_addr_i       (target_sta_addr_i),
    .target_dyn_addr_i       (target_dyn_addr_i),
    .target_dyn_addr_valid_i (target_dyn_addr_valid_i),
    .rst_action_o            (rst_action_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Queue model, sampled mid-cycle
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (rx_queue_wvalid_o) data_seen.push_back(rx_queue_wdata_o);
      if (rx_desc_queue_wvalid_o) desc_seen.push_back(rx_desc_queue_wdata_o);
      if (bus_addr_valid_o) addr_seen.push_back(bus_addr_o);
      if (bus_start_o) start_cnt = start_cnt + 1;
      if (bus_rstart_o) rstart_cnt = rstart_cnt + 1;
      if (bus_stop_o) stop_cnt = stop_cnt + 1;
    end
  end

  initial begin
    repeat (N_ROWS * ENTRY_CYCLES * 2) @(posedge clk_i);
    $display("Watchdog expired before the last transfer finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  task automatic compare_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s expected %0h actual %0h", test, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Write-only address rules of both modes
  function automatic logic addr_accepted(input logic i3c, input logic dyn_valid,
                                         input logic [7:0] hdr);
    logic [6:0] addr;
    addr = hdr[7:1];
    if (hdr[0]) return 1'b0;
    if (!i3c) return addr == STA_ADDR;
    return (dyn_valid && addr == DYN_ADDR) || addr == `STBY_BCAST_ADDR;
  endfunction

  // SCL period is 16 clocks, SDA changes mid-low
  task automatic send_start();
    repeat (4) @(posedge clk_i);
    sda_drv <= 1'b0;
    repeat (4) @(posedge clk_i);
    scl_drv <= 1'b0;
  endtask

  task automatic send_rstart();
    repeat (4) @(posedge clk_i);
    sda_drv <= 1'b1;
    repeat (4) @(posedge clk_i);
    scl_drv <= 1'b1;
    repeat (4) @(posedge clk_i);
    sda_drv <= 1'b0;
    repeat (4) @(posedge clk_i);
    scl_drv <= 1'b0;
  endtask

  task automatic send_stop();
    repeat (4) @(posedge clk_i);
    sda_drv <= 1'b0;
    repeat (4) @(posedge clk_i);
    scl_drv <= 1'b1;
    repeat (4) @(posedge clk_i);
    sda_drv <= 1'b1;
    repeat (4) @(posedge clk_i);
  endtask

  task automatic write_byte(input logic [7:0] value, output logic ack);
    for (int i = 7; i >= 0; i--) begin
      repeat (4) @(posedge clk_i);
      sda_drv <= value[i];
      repeat (4) @(posedge clk_i);
      scl_drv <= 1'b1;
      repeat (8) @(posedge clk_i);
      scl_drv <= 1'b0;
    end
    // Ninth clock with SDA released
    repeat (4) @(posedge clk_i);
    sda_drv <= 1'b1;
    repeat (4) @(posedge clk_i);
    scl_drv <= 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    ack = ~sda_bus;
    repeat (4) @(posedge clk_i);
    scl_drv <= 1'b0;
  endtask

  task automatic run_row(input int idx);
    test_row_t   row;
    logic [7:0]  bytes [4];
    logic [31:0] rnd;
    logic        ack;
    logic        began_rstart;
    logic        matched;
    logic        bcast;
    logic        ovf;
    logic        is_ccc;
    int          data_base;
    int          desc_base;
    int          addr_base;
    int          start_base;
    int          rstart_base;
    int          stop_base;
    logic [7:0]  exp_data [$];
    row = rows[idx];
    began_rstart = in_rstart;
    for (int b = 0; b < 4; b++) begin
      rnd = $random(seed);
      bytes[b] = rnd[7:0];
    end
    if (row.rstact) bytes[0] = `STBY_CCC_RSTACT;
    @(posedge clk_i);
    i3c_mode_i              <= row.i3c;
    target_dyn_addr_valid_i <= row.dyn_valid;
    data_base   = data_seen.size();
    desc_base   = desc_seen.size();
    addr_base   = addr_seen.size();
    start_base  = start_cnt;
    rstart_base = rstart_cnt;
    stop_base   = stop_cnt;
    if (!began_rstart) send_start();
    write_byte(row.addr_byte, ack);
    compare_value(names[idx], "address ack", 32'(row.ack_mask[0]), 32'(ack));
    for (int b = 0; b < row.nbytes; b++) begin
      rx_queue_wready_i <= row.wready_mask[b];
      write_byte(bytes[b], ack);
      compare_value(names[idx], "data ack", 32'(row.ack_mask[b+1]), 32'(ack));
    end
    rx_queue_wready_i <= 1'b1;
    if (row.end_rstart) send_rstart();
    else send_stop();
    in_rstart = row.end_rstart;
    repeat (8) @(posedge clk_i);

    // Expected results from the address, CCC and back-pressure rules
    matched = addr_accepted(row.i3c, row.dyn_valid, row.addr_byte);
    bcast   = matched && row.i3c && (row.addr_byte[7:1] == `STBY_BCAST_ADDR);
    ovf     = 1'b0;
    for (int b = 0; b < row.nbytes; b++) begin
      if (matched && !bcast) begin
        if (row.wready_mask[b]) exp_data.push_back(bytes[b]);
        else ovf = 1'b1;
      end
    end
    is_ccc = bcast && row.nbytes != 0 && bytes[0] == `STBY_CCC_RSTACT;
    if (is_ccc && row.nbytes > 1) exp_rst_action = bytes[1];

    compare_value(names[idx], "start pulses", began_rstart ? 0 : 1, start_cnt - start_base);
    compare_value(names[idx], "rstart pulses", 32'(row.end_rstart), rstart_cnt - rstart_base);
    compare_value(names[idx], "stop pulses", 32'(!row.end_rstart), stop_cnt - stop_base);
    compare_value(names[idx], "address reports", 1, addr_seen.size() - addr_base);
    compare_value(names[idx], "bus address", 32'(row.addr_byte), 32'(addr_seen[addr_base]));
    compare_value(names[idx], "data count", exp_data.size(), data_seen.size() - data_base);
    foreach (exp_data[i]) begin
      compare_value(names[idx], "data", 32'(exp_data[i]), 32'(data_seen[data_base + i]));
    end
    compare_value(names[idx], "descriptor count", matched ? 1 : 0,
                  desc_seen.size() - desc_base);
    if (matched) begin
      compare_value(names[idx], "descriptor",
                    {6'd0, is_ccc, ovf, 1'b0, row.addr_byte[7:1], 16'(exp_data.size())},
                    desc_seen[desc_base]);
    end
    compare_value(names[idx], "reset action", 32'(exp_rst_action), 32'(rst_action_o));
  endtask

  task automatic load_table();
    rows[0] = '{1'b0, 1'b0, 8'h58, 3'd4, 1'b0, 1'b0, 4'b1111, 5'b11111};
    names[0] = "i2c_write";
    rows[1] = '{1'b0, 1'b0, 8'h66, 3'd2, 1'b0, 1'b0, 4'b1111, 5'b00000};
    names[1] = "i2c_wrong_addr";
    rows[2] = '{1'b0, 1'b0, 8'h59, 3'd1, 1'b0, 1'b0, 4'b1111, 5'b00000};
    names[2] = "i2c_read_nack";
    rows[3] = '{1'b1, 1'b1, 8'h6A, 3'd3, 1'b0, 1'b0, 4'b1111, 5'b01111};
    names[3] = "i3c_dyn_write";
    rows[4] = '{1'b1, 1'b1, 8'h58, 3'd2, 1'b0, 1'b0, 4'b1111, 5'b00000};
    names[4] = "i3c_static_nack";
    rows[5] = '{1'b1, 1'b1, 8'hFC, 3'd2, 1'b1, 1'b0, 4'b1111, 5'b00111};
    names[5] = "i3c_rstact";
    rows[6] = '{1'b0, 1'b0, 8'h58, 3'd4, 1'b0, 1'b0, 4'b1011, 5'b10111};
    names[6] = "i2c_overflow";
    rows[7] = '{1'b0, 1'b0, 8'h58, 3'd2, 1'b0, 1'b1, 4'b1111, 5'b00111};
    names[7] = "rstart_first";
    rows[8] = '{1'b0, 1'b0, 8'h58, 3'd1, 1'b0, 1'b0, 4'b1111, 5'b00011};
    names[8] = "rstart_second";
    rows[9] = '{1'b1, 1'b0, 8'h6A, 3'd1, 1'b0, 1'b0, 4'b1111, 5'b00000};
    names[9] = "i3c_dyn_invalid";
  endtask

  initial begin
    seed           = 32'h723f;
    in_rstart      = 1'b0;
    exp_rst_action = 8'h00;
    load_table();
    arst_n_i                <= 1'b0;
    scl_drv                 <= 1'b1;
    sda_drv                 <= 1'b1;
    rx_queue_wready_i       <= 1'b1;
    rx_desc_queue_wready_i  <= 1'b1;
    i3c_mode_i              <= 1'b0;
    target_sta_addr_i       <= STA_ADDR;
    target_dyn_addr_i       <= DYN_ADDR;
    target_dyn_addr_valid_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    compare_value("reset", "sda_o", 1, 32'(sda_o));
    compare_value("reset", "reset action", 0, 32'(rst_action_o));
    for (int i = 0; i < N_ROWS; i++) begin
      run_row(i);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
standby_pkg.sv
bus_cond_detect.sv
bus_byte_shifter.sv
target_responder.sv
controller_standby.sv
tb_controller_standby.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TOP        ?= tb_controller_standby
RTL_TOP    ?= controller_standby
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
